// ==== include/fpu_settings.svh ====
// ========================================
// FPU width and size settings
// ========================================
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// Single-precision fields
`define FP_EXP_W 8
`define FP_MANT_W 23
`define FP_EXP_BIAS 127

// Extended X/Y registers, normalized leading one at bit 47
`define EXT_FRAC_W 50
`define EXT_EXP_W 9

// Micro-program store
`define UPC_W 5
`define UROM_DEPTH 16

`endif

// ==== source/rv32f_pkg.sv ====
// ========================================
// RV32F instruction encoding
// ========================================
package rv32f_pkg;

   // Instruction bits 31..2, seen as R-type or as R4-type
   typedef union packed {
      struct packed {
         logic [4:0] funct5;
         logic [1:0] fmt;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] rm;
         logic [4:0] rd;
         logic [4:0] opcode;
      } r_fields;
      struct packed {
         logic [4:0] rs3;
         logic [1:0] fmt;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] rm;
         logic [4:0] rd;
         logic [4:0] opcode;
      } r4_fields;
   } instr_word_u;

   // funct5 values of OP-FP
   localparam logic [4:0] F5_FADD    = 5'b00000;
   localparam logic [4:0] F5_FSUB    = 5'b00001;
   localparam logic [4:0] F5_FMUL    = 5'b00010;
   localparam logic [4:0] F5_FSGNJ   = 5'b00100;
   localparam logic [4:0] F5_FMINMAX = 5'b00101;
   localparam logic [4:0] F5_FCMP    = 5'b10100;
   localparam logic [4:0] F5_FCLASS  = 5'b11100;
   localparam logic [4:0] F5_FMVWX   = 5'b11110;

   // One-hot operation vector positions
   // Sign, class and move ops stay contiguous at the top
   localparam int OP_FADD   = 0;
   localparam int OP_FSUB   = 1;
   localparam int OP_FMUL   = 2;
   localparam int OP_FMADD  = 3;
   localparam int OP_FMSUB  = 4;
   localparam int OP_FNMSUB = 5;
   localparam int OP_FNMADD = 6;
   localparam int OP_FEQ    = 7;
   localparam int OP_FLT    = 8;
   localparam int OP_FLE    = 9;
   localparam int OP_FMIN   = 10;
   localparam int OP_FMAX   = 11;
   localparam int OP_FSGNJ  = 12;
   localparam int OP_FSGNJN = 13;
   localparam int OP_FSGNJX = 14;
   localparam int OP_FCLASS = 15;
   localparam int OP_FMVXW  = 16;
   localparam int OP_FMVWX  = 17;
   localparam int OP_COUNT  = 18;

endpackage

// ==== source/fpu_micro_pkg.sv ====
// ========================================
// FPU micro-operations
// ========================================
`include "fpu_settings.svh"

package fpu_micro_pkg;

   localparam int UOP_W = 4;

   // Micro-operation codes
   localparam logic [UOP_W-1:0] UOP_READY       = 4'd0;
   // X <- A, Y <- B
   localparam logic [UOP_W-1:0] UOP_LOAD_XY     = 4'd1;
   // X <- norm(A*B), Y <- C
   localparam logic [UOP_W-1:0] UOP_LOAD_XY_MUL = 4'd2;
   // Larger magnitude into Y, X negated on sign mismatch
   localparam logic [UOP_W-1:0] UOP_ADD_SWAP    = 4'd3;
   // Align X on the exponent of Y
   localparam logic [UOP_W-1:0] UOP_ADD_SHIFT   = 4'd4;
   localparam logic [UOP_W-1:0] UOP_ADD_ADD     = 4'd5;
   localparam logic [UOP_W-1:0] UOP_ADD_NORM    = 4'd6;
   localparam logic [UOP_W-1:0] UOP_CMP         = 4'd7;
   localparam logic [UOP_W-1:0] UOP_MIN_MAX     = 4'd8;

   // ROM word is {exit, uop}
   localparam int UOP_EXIT_BIT = UOP_W;

   // Program entry points, address 0 holds the idle word
   localparam logic [`UPC_W-1:0] PROG_CMP    = 5'd1;
   localparam logic [`UPC_W-1:0] PROG_ADD    = 5'd3;
   localparam logic [`UPC_W-1:0] PROG_MUL    = 5'd8;
   localparam logic [`UPC_W-1:0] PROG_MADD   = 5'd9;
   localparam logic [`UPC_W-1:0] PROG_MINMAX = 5'd14;

endpackage

// ==== source/leading_zero_counter.sv ====
// ========================================
// Leading zero counter
// ========================================
module leading_zero_counter #(
   parameter int W = 64
) (
   input  logic [W-1:0]         in,
   output logic [$clog2(W)-1:0] count
);

   generate
      if (W == 2) begin : g_leaf
         assign count = !in[1];
      end else begin : g_split
         logic [$clog2(W)-2:0] half_count;
         logic                 upper_empty;

         // Count in the upper half, or the lower half when it is empty
         assign upper_empty = ~|in[W-1 -: W/2];

         leading_zero_counter #(.W(W/2)) u_half (
            .in    (upper_empty ? in[W/2-1:0] : in[W-1 -: W/2]),
            .count (half_count)
         );

         assign count = {upper_empty, half_count};
      end
   endgenerate

endmodule

// ==== source/rv32f_decoder.sv ====
// ========================================
// RV32F instruction decoder
// ========================================
module rv32f_decoder (
   input  rv32f_pkg::instr_word_u         instr,
   input  logic                           wr,
   output logic [rv32f_pkg::OP_COUNT-1:0] op
);

   logic       is_r4;
   logic [1:0] r4_sel;
   logic [4:0] f5;
   logic [2:0] rm;
   logic       rs2_lsb;

   // Opcode bit 4 of the word is clear for the fused group
   assign is_r4   = !instr.r_fields.opcode[2];
   // FMADD, FMSUB, FNMSUB, FNMADD in opcode order
   assign r4_sel  = instr.r4_fields.opcode[1:0];
   assign f5      = instr.r_fields.funct5;
   assign rm      = instr.r_fields.rm;
   assign rs2_lsb = instr.r_fields.rs2[0];

   always_comb begin
      op = '0;
      if (is_r4) begin
         op[rv32f_pkg::OP_FMADD]  = (r4_sel == 2'b00);
         op[rv32f_pkg::OP_FMSUB]  = (r4_sel == 2'b01);
         op[rv32f_pkg::OP_FNMSUB] = (r4_sel == 2'b10);
         op[rv32f_pkg::OP_FNMADD] = (r4_sel == 2'b11);
      end else begin
         // rm is a rounding mode here, ignored
         op[rv32f_pkg::OP_FADD]   = (f5 == rv32f_pkg::F5_FADD);
         op[rv32f_pkg::OP_FSUB]   = (f5 == rv32f_pkg::F5_FSUB);
         op[rv32f_pkg::OP_FMUL]   = (f5 == rv32f_pkg::F5_FMUL);
         // rm selects the variant
         op[rv32f_pkg::OP_FSGNJ]  = (f5 == rv32f_pkg::F5_FSGNJ) && (rm == 3'b000);
         op[rv32f_pkg::OP_FSGNJN] = (f5 == rv32f_pkg::F5_FSGNJ) && (rm == 3'b001);
         op[rv32f_pkg::OP_FSGNJX] = (f5 == rv32f_pkg::F5_FSGNJ) && (rm == 3'b010);
         op[rv32f_pkg::OP_FMIN]   = (f5 == rv32f_pkg::F5_FMINMAX) && (rm == 3'b000);
         op[rv32f_pkg::OP_FMAX]   = (f5 == rv32f_pkg::F5_FMINMAX) && (rm == 3'b001);
         op[rv32f_pkg::OP_FLE]    = (f5 == rv32f_pkg::F5_FCMP) && (rm == 3'b000);
         op[rv32f_pkg::OP_FLT]    = (f5 == rv32f_pkg::F5_FCMP) && (rm == 3'b001);
         op[rv32f_pkg::OP_FEQ]    = (f5 == rv32f_pkg::F5_FCMP) && (rm == 3'b010);
         // Unary ops carry rs2 = 0
         op[rv32f_pkg::OP_FMVXW]  = (f5 == rv32f_pkg::F5_FCLASS) && (rm == 3'b000)
                                    && !rs2_lsb;
         op[rv32f_pkg::OP_FCLASS] = (f5 == rv32f_pkg::F5_FCLASS) && (rm == 3'b001)
                                    && !rs2_lsb;
         op[rv32f_pkg::OP_FMVWX]  = (f5 == rv32f_pkg::F5_FMVWX) && (rm == 3'b000)
                                    && !rs2_lsb;
      end
   end

   // Sequencer start address and source select both rely on a single op
   always_comb begin
      if (wr) begin
         assert final ($onehot0(op))
            else $error("decoder gives more than one op at wr");
      end
   end

endmodule

// ==== source/fpu_microsequencer.sv ====
// ========================================
// FPU micro-program sequencer
// ========================================
`include "fpu_settings.svh"

module fpu_microsequencer (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               wr,
   input  logic [rv32f_pkg::OP_COUNT-1:0]     op,
   output logic [fpu_micro_pkg::UOP_W-1:0]    uop,
   output logic                               busy
);

   localparam int WORD_W = fpu_micro_pkg::UOP_W + 1;
   localparam int ADDR_W = $clog2(`UROM_DEPTH);

   // Micro-program store, {exit, uop} per word
   localparam logic [WORD_W-1:0] UROM [`UROM_DEPTH] = '{
      {1'b1, fpu_micro_pkg::UOP_READY},
      // Compare
      {1'b0, fpu_micro_pkg::UOP_LOAD_XY},
      {1'b1, fpu_micro_pkg::UOP_CMP},
      // Add and subtract
      {1'b0, fpu_micro_pkg::UOP_LOAD_XY},
      {1'b0, fpu_micro_pkg::UOP_ADD_SWAP},
      {1'b0, fpu_micro_pkg::UOP_ADD_SHIFT},
      {1'b0, fpu_micro_pkg::UOP_ADD_ADD},
      {1'b1, fpu_micro_pkg::UOP_ADD_NORM},
      // Multiply
      {1'b1, fpu_micro_pkg::UOP_LOAD_XY_MUL},
      // Fused multiply-add
      {1'b0, fpu_micro_pkg::UOP_LOAD_XY_MUL},
      {1'b0, fpu_micro_pkg::UOP_ADD_SWAP},
      {1'b0, fpu_micro_pkg::UOP_ADD_SHIFT},
      {1'b0, fpu_micro_pkg::UOP_ADD_ADD},
      {1'b1, fpu_micro_pkg::UOP_ADD_NORM},
      // Min and max
      {1'b0, fpu_micro_pkg::UOP_LOAD_XY},
      {1'b1, fpu_micro_pkg::UOP_MIN_MAX}
   };

   logic [`UPC_W-1:0] upc;
   logic [`UPC_W-1:0] upc_next;
   logic [`UPC_W-1:0] start;
   logic [WORD_W-1:0] uword;

   // Entry point of the decoded op, 0 for single-cycle ops
   always_comb begin
      start = '0;
      if (op[rv32f_pkg::OP_FEQ] | op[rv32f_pkg::OP_FLT] | op[rv32f_pkg::OP_FLE])
         start = fpu_micro_pkg::PROG_CMP;
      else if (op[rv32f_pkg::OP_FADD] | op[rv32f_pkg::OP_FSUB])
         start = fpu_micro_pkg::PROG_ADD;
      else if (op[rv32f_pkg::OP_FMUL])
         start = fpu_micro_pkg::PROG_MUL;
      else if (|op[rv32f_pkg::OP_FNMADD:rv32f_pkg::OP_FMADD])
         start = fpu_micro_pkg::PROG_MADD;
      else if (op[rv32f_pkg::OP_FMIN] | op[rv32f_pkg::OP_FMAX])
         start = fpu_micro_pkg::PROG_MINMAX;
   end

   // wr restarts, exit word returns to idle
   assign upc_next = wr ? start :
                     uword[fpu_micro_pkg::UOP_EXIT_BIT] ? '0 : upc + 1'b1;

   // Word is fetched with its address, so it is current in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         upc   <= '0;
         uword <= UROM[0];
      end else begin
         upc   <= upc_next;
         uword <= UROM[upc_next[ADDR_W-1:0]];
      end
   end

   assign uop  = uword[fpu_micro_pkg::UOP_W-1:0];
   assign busy = (uop != fpu_micro_pkg::UOP_READY);

   // Every program ends on an exit word inside the store
   assert property (@(posedge clk) disable iff (!rst_n)
      upc <= `UPC_W'(`UROM_DEPTH - 1))
      else $error("micro-PC ran past the last ROM word");

endmodule

// ==== source/fpu_datapath.sv ====
// ========================================
// FPU multiply-add datapath
// ========================================
`include "fpu_settings.svh"

module fpu_datapath (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            wr,
   input  logic [31:0]                     rs1,
   input  logic [31:0]                     rs2,
   input  logic [31:0]                     rs3,
   input  logic [rv32f_pkg::OP_COUNT-1:0]  op,
   input  logic [fpu_micro_pkg::UOP_W-1:0] uop,
   output logic [31:0]                     arith_result
);

   localparam int MW   = `FP_MANT_W;
   localparam int XW   = `FP_EXP_W;
   localparam int FW   = `EXT_FRAC_W;
   localparam int EW   = `EXT_EXP_W;
   // Position of the leading one of a normalized X
   localparam int LEAD = FW - 3;
   localparam int CW   = 6;

   logic [31:0]                    a, b, c;
   logic [rv32f_pkg::OP_COUNT-1:0] op_q;

   // Value is +/- frac * 2^(exp - bias - 47)
   logic                  x_sign, y_sign;
   logic signed [EW-1:0]  x_exp, y_exp, x_exp_norm;
   logic signed [FW-1:0]  x_frac, y_frac;
   logic [CW-1:0]         norm_lshamt;

   // Operand fields, hidden one added, zero when exponent is 0
   logic [XW-1:0]     a_exp, b_exp, c_exp;
   logic [MW:0]       a_frac, b_frac, c_frac;
   logic [2*MW+1:0]   prod_frac;
   logic signed [EW:0] prod_exp;
   logic              prod_zero;

   logic signed [FW:0]   frac_sum, frac_diff;
   logic signed [EW-1:0] exp_diff;
   logic [CW-1:0]        sum_clz;

   logic exp_eq, frac_eq, abs_eq;
   logic abs_x_lt_y, abs_y_lt_x;
   logic x_lt_y, x_le_y, x_eq_y;
   logic cmp_bit;
   logic [31:0] x_word, y_word, out_word;

   // Subnormals read as zero
   function automatic logic [31:0] flush(input logic [31:0] w);
      return (|w[MW +: XW]) ? w : 32'b0;
   endfunction

   always_ff @(posedge clk) begin
      if (wr) begin
         a <= flush(rs1);
         b <= flush(rs2);
         c <= flush(rs3);
      end
   end

   assign a_exp  = a[MW +: XW];
   assign b_exp  = b[MW +: XW];
   assign c_exp  = c[MW +: XW];
   assign a_frac = (a_exp == '0) ? '0 : {1'b1, a[MW-1:0]};
   assign b_frac = (b_exp == '0) ? '0 : {1'b1, b[MW-1:0]};
   assign c_frac = (c_exp == '0) ? '0 : {1'b1, c[MW-1:0]};

   // Product leading one lands on bit 47 or 46
   assign prod_frac = a_frac * b_frac;
   assign prod_exp  = $signed({2'b0, a_exp} + {2'b0, b_exp} + {9'b0, prod_frac[2*MW+1]}
                              - 10'(`FP_EXP_BIAS));
   // Underflow flushes to zero
   assign prod_zero = (prod_exp <= 0) || !(|prod_frac[2*MW+1 -: 2]);

   assign frac_sum  = y_frac + x_frac;
   assign frac_diff = y_frac - x_frac;
   assign exp_diff  = y_exp - x_exp;

   leading_zero_counter #(.W(64)) u_lzc (
      .in    ({{(64 - FW - 1){1'b0}}, frac_sum}),
      .count (sum_clz)
   );

   // Magnitude order from exponent first, then fraction
   assign exp_eq     = (exp_diff == '0);
   assign frac_eq    = (frac_diff == '0);
   assign abs_eq     = exp_eq && frac_eq;
   assign abs_x_lt_y = (!exp_diff[EW-1] && !exp_eq) || (exp_eq && !frac_eq && !frac_diff[FW]);
   assign abs_y_lt_x = exp_diff[EW-1] || (exp_eq && frac_diff[FW]);

   // Signed order, negative operand flips the magnitude test
   assign x_lt_y = (x_sign && !y_sign) || (x_sign && y_sign && abs_y_lt_x)
                   || (!x_sign && !y_sign && abs_x_lt_y);
   assign x_le_y = (x_sign && !y_sign) || (x_sign && y_sign && (abs_y_lt_x || abs_eq))
                   || (!x_sign && !y_sign && (abs_x_lt_y || abs_eq));
   assign x_eq_y = abs_eq && (x_sign == y_sign);

   assign cmp_bit = (op_q[rv32f_pkg::OP_FLT] && x_lt_y) || (op_q[rv32f_pkg::OP_FLE] && x_le_y)
                    || (op_q[rv32f_pkg::OP_FEQ] && x_eq_y);

   // Truncation keeps the 23 bits under the leading one
   assign x_word = {x_sign, x_exp[XW-1:0], x_frac[LEAD-1 -: MW]};
   assign y_word = {y_sign, y_exp[XW-1:0], y_frac[LEAD-1 -: MW]};
   assign out_word = (uop == fpu_micro_pkg::UOP_CMP) ? {31'b0, cmp_bit} :
                     (x_lt_y ^ op_q[rv32f_pkg::OP_FMAX]) ? x_word : y_word;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q   <= '0;
         x_sign <= 1'b0;
         x_exp  <= '0;
         x_frac <= '0;
      end else if (wr) begin
         op_q <= op;
      end else begin
         case (uop)
            fpu_micro_pkg::UOP_LOAD_XY: begin
               x_sign <= a[31];
               x_exp  <= {1'b0, a_exp};
               x_frac <= {2'b0, a_frac, {(FW - MW - 3){1'b0}}};
               // FSUB adds the negated B
               y_sign <= b[31] ^ op_q[rv32f_pkg::OP_FSUB];
               y_exp  <= {1'b0, b_exp};
               y_frac <= {2'b0, b_frac, {(FW - MW - 3){1'b0}}};
            end
            fpu_micro_pkg::UOP_LOAD_XY_MUL: begin
               // FNMADD is -(a*b+c), FNMSUB is -(a*b-c)
               x_sign <= a[31] ^ b[31] ^ (op_q[rv32f_pkg::OP_FNMSUB]
                                          | op_q[rv32f_pkg::OP_FNMADD]);
               x_exp  <= prod_zero ? '0 : prod_exp[EW-1:0];
               x_frac <= prod_zero ? '0 :
                         prod_frac[2*MW+1] ? {2'b0, prod_frac} : {1'b0, prod_frac, 1'b0};
               y_sign <= c[31] ^ (op_q[rv32f_pkg::OP_FMSUB] | op_q[rv32f_pkg::OP_FNMADD]);
               y_exp  <= {1'b0, c_exp};
               y_frac <= {2'b0, c_frac, {(FW - MW - 3){1'b0}}};
            end
            fpu_micro_pkg::UOP_ADD_SWAP: begin
               // Negate before the shift so truncation stays toward zero
               if (abs_y_lt_x) begin
                  x_frac <= (x_sign ^ y_sign) ? -y_frac : y_frac;
                  y_frac <= x_frac;
                  x_exp  <= y_exp;
                  y_exp  <= x_exp;
                  x_sign <= y_sign;
                  y_sign <= x_sign;
               end else if (x_sign ^ y_sign) begin
                  x_frac <= -x_frac;
               end
            end
            fpu_micro_pkg::UOP_ADD_SHIFT: begin
               // Arithmetic shift keeps a negated X negative
               x_frac <= x_frac >>> exp_diff;
               x_exp  <= y_exp;
            end
            fpu_micro_pkg::UOP_ADD_ADD: begin
               x_frac      <= frac_sum[FW-1:0];
               x_sign      <= y_sign;
               // Leading one sits at 63 - clz
               norm_lshamt <= sum_clz - CW'(63 - LEAD);
               x_exp_norm  <= x_exp + EW'(63 - LEAD) - $signed({3'b0, sum_clz});
            end
            fpu_micro_pkg::UOP_ADD_NORM: begin
               if (x_exp_norm <= 0 || x_frac == '0) begin
                  x_frac <= '0;
                  x_exp  <= '0;
               end else begin
                  // Carry out of the add moves right by one
                  x_frac <= x_frac[LEAD+1] ? x_frac >>> 1 : x_frac << norm_lshamt;
                  x_exp  <= x_exp_norm;
               end
            end
            fpu_micro_pkg::UOP_CMP, fpu_micro_pkg::UOP_MIN_MAX: begin
               // Word result goes back into X so it reads out unchanged
               x_sign <= out_word[31];
               x_exp  <= {1'b0, out_word[MW +: XW]};
               x_frac <= {3'b0, out_word[MW-1:0], {(FW - MW - 3){1'b0}}};
            end
            default: ;
         endcase
      end
   end

   assign arith_result = x_word;

   // Swap must have left the larger magnitude in Y
   assert property (@(posedge clk) disable iff (!rst_n)
      (uop == fpu_micro_pkg::UOP_ADD_SHIFT) |-> !abs_y_lt_x)
      else $error("ADD_SHIFT sees |Y| < |X|");

endmodule

// ==== source/fp_sign_class.sv ====
// ========================================
// Sign injection, classify and move
// ========================================
module fp_sign_class (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           wr,
   input  logic [31:0]                    rs1,
   input  logic [31:0]                    rs2,
   input  logic [rv32f_pkg::OP_COUNT-1:0] op,
   output logic [31:0]                    sc_result
);

   logic       sgn, exp_zero, exp_ones, mant_zero;
   logic [9:0] class_mask;

   assign sgn       = rs1[31];
   assign exp_zero  = (rs1[30:23] == 8'h00);
   assign exp_ones  = (rs1[30:23] == 8'hff);
   assign mant_zero = (rs1[22:0] == '0);

   // RISC-V class bits, 9 down to 0
   assign class_mask = {
      exp_ones && rs1[22],                     // quiet NaN
      exp_ones && !rs1[22] && !mant_zero,      // signaling NaN
      !sgn && exp_ones && mant_zero,           // +inf
      !sgn && !exp_zero && !exp_ones,          // +normal
      !sgn && exp_zero && !mant_zero,          // +subnormal
      !sgn && exp_zero && mant_zero,           // +0
      sgn && exp_zero && mant_zero,            // -0
      sgn && exp_zero && !mant_zero,           // -subnormal
      sgn && !exp_zero && !exp_ones,           // -normal
      sgn && exp_ones && mant_zero             // -inf
   };

   // Holds until the next single-cycle op
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sc_result <= '0;
      end else if (wr) begin
         if (op[rv32f_pkg::OP_FSGNJ])
            sc_result <= {rs2[31], rs1[30:0]};
         else if (op[rv32f_pkg::OP_FSGNJN])
            sc_result <= {!rs2[31], rs1[30:0]};
         else if (op[rv32f_pkg::OP_FSGNJX])
            sc_result <= {rs1[31] ^ rs2[31], rs1[30:0]};
         else if (op[rv32f_pkg::OP_FCLASS])
            sc_result <= {22'b0, class_mask};
         // Bit pattern moves either way unchanged
         else if (op[rv32f_pkg::OP_FMVXW] | op[rv32f_pkg::OP_FMVWX])
            sc_result <= rs1;
      end
   end

endmodule

// ==== source/rv32f_fpu.sv ====
// ========================================
// RV32F floating-point unit
// ========================================
module rv32f_fpu (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wr,
   input  logic [29:0] instr,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   input  logic [31:0] rs3,
   output logic        busy,
   output logic [31:0] result
);

   logic [rv32f_pkg::OP_COUNT-1:0]  op;
   logic [fpu_micro_pkg::UOP_W-1:0] uop;
   logic [31:0]                     arith_result;
   logic [31:0]                     sc_result;
   logic                            single_op;
   logic                            sel_sc;

   rv32f_decoder u_decoder (
      .instr (instr),
      .wr    (wr),
      .op    (op)
   );

   fpu_microsequencer u_seq (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (wr),
      .op    (op),
      .uop   (uop),
      .busy  (busy)
   );

   fpu_datapath u_datapath (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr           (wr),
      .rs1          (rs1),
      .rs2          (rs2),
      .rs3          (rs3),
      .op           (op),
      .uop          (uop),
      .arith_result (arith_result)
   );

   fp_sign_class u_sign_class (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr        (wr),
      .rs1       (rs1),
      .rs2       (rs2),
      .op        (op),
      .sc_result (sc_result)
   );

   // Sign, class and move ops sit at the top of the op vector
   assign single_op = |op[rv32f_pkg::OP_FMVWX:rv32f_pkg::OP_FSGNJ];

   // Output follows the unit of the last accepted instruction
   always_ff @(posedge clk) begin
      if (!rst_n)
         sel_sc <= 1'b0;
      else if (wr)
         sel_sc <= single_op;
   end

   assign result = sel_sc ? sc_result : arith_result;

endmodule

// ==== testbench/tb_clock_gen.sv ====
// ========================================
// Testbench clock and reset
// ========================================
module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // Period of 10
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held low for 8 rising edges
   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// ==== testbench/tb_rv32f_fpu.sv ====
// ========================================
// RV32F FPU testbench
// ========================================
module tb_rv32f_fpu;

   localparam int NUM_PAT  = 35;
   localparam int PAT_COLS = 6;
   localparam int NUM_RAND = 8;
   // 16 cycles per test plus reset and slack
   localparam int CYCLE_LIMIT = 8 + (NUM_PAT + NUM_RAND + 2) * 16;

   logic        clk;
   logic        rst_n;
   logic        wr;
   logic [29:0] instr;
   logic [31:0] rs1, rs2, rs3;
   logic        busy;
   logic [31:0] result;

   logic [31:0] pat_mem [0:NUM_PAT*PAT_COLS-1];
   int          cycles = 0;
   int          tests = 0;
   int          fails = 0;
   integer      seed = 32'h1f7704a3;

   tb_clock_gen u_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   rv32f_fpu dut (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr     (wr),
      .instr  (instr),
      .rs1    (rs1),
      .rs2    (rs2),
      .rs3    (rs3),
      .busy   (busy),
      .result (result)
   );

   // Mnemonic of an instruction word, for the report lines
   function automatic string op_name(input logic [31:0] ins);
      case (ins)
         32'h00000014: return "FADD";
         32'h02000014: return "FSUB";
         32'h04000014: return "FMUL";
         32'h00000010: return "FMADD";
         32'h00000011: return "FMSUB";
         32'h00000012: return "FNMSUB";
         32'h00000013: return "FNMADD";
         32'h08000014: return "FSGNJ";
         32'h08000414: return "FSGNJN";
         32'h08000814: return "FSGNJX";
         32'h0A000014: return "FMIN";
         32'h0A000414: return "FMAX";
         32'h28000014: return "FLE";
         32'h28000414: return "FLT";
         32'h28000814: return "FEQ";
         32'h38000014: return "FMV.X.W";
         32'h38000414: return "FCLASS";
         32'h3C000014: return "FMV.W.X";
         default:      return "UNKNOWN";
      endcase
   endfunction

   // One instruction: strobe wr, count busy cycles, then check result
   task automatic run_test(input string name, input logic [31:0] ins,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c, input logic [31:0] exp_res,
                           input int exp_cycles);
      int cnt;
      bit ok;
      cnt = 0;
      ok  = 1'b1;
      @(posedge clk);
      wr    <= 1'b1;
      instr <= ins[29:0];
      rs1   <= a;
      rs2   <= b;
      rs3   <= c;
      @(posedge clk);
      wr <= 1'b0;
      // Sample away from the rising edge
      @(negedge clk);
      while (busy) begin
         cnt++;
         @(negedge clk);
      end
      assert (cnt == exp_cycles)
         else begin
            $display("Error: %s busy cycles expected %0d actual %0d", name, exp_cycles, cnt);
            ok = 1'b0;
         end
      assert (result === exp_res)
         else begin
            $display("Error: %s expected %h actual %h", name, exp_res, result);
            ok = 1'b0;
         end
      tests++;
      if (!ok)
         fails++;
      $display("%-16s %s", name, ok ? "ok" : "mismatch");
   endtask

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("run stopped, cycle limit reached before the tests finished");
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] ra, rb, ins, exp_res;
      logic [1:0]  variant;
      logic        sgn;
      wr    = 1'b0;
      instr = '0;
      rs1   = '0;
      rs2   = '0;
      rs3   = '0;
      $readmemh("testbench/fpu_patterns.hex", pat_mem);

      // Reset is still unknown at time 0
      while (rst_n !== 1'b1)
         @(posedge clk);
      @(negedge clk);
      // Idle state straight after reset
      tests++;
      assert (!busy && result == 32'h0)
         else begin
            $display("Error: reset expected busy 0 result %h actual busy %0d result %h",
                     32'h0, busy, result);
            fails++;
         end
      $display("%-16s done", "reset");

      // File patterns: instr, rs1, rs2, rs3, expected result, busy cycles
      for (int i = 0; i < NUM_PAT; i++) begin
         run_test($sformatf("%0d_%s", i, op_name(pat_mem[i*PAT_COLS])),
                  pat_mem[i*PAT_COLS], pat_mem[i*PAT_COLS+1], pat_mem[i*PAT_COLS+2],
                  pat_mem[i*PAT_COLS+3], pat_mem[i*PAT_COLS+4], pat_mem[i*PAT_COLS+5]);
      end

      // Random sign injection, sign bit from the RISC-V rule
      for (int i = 0; i < NUM_RAND; i++) begin
         ra      = $random(seed);
         rb      = $random(seed);
         variant = 2'($random(seed));
         if (variant == 2'd3)
            variant = 2'd0;
         ins = 32'h08000014 | (32'(variant) << 10);
         case (variant)
            2'd0:    sgn = rb[31];
            2'd1:    sgn = !rb[31];
            default: sgn = ra[31] ^ rb[31];
         endcase
         exp_res = {sgn, ra[30:0]};
         run_test($sformatf("rand%0d_%s", i, op_name(ins)), ins, ra, rb, 32'h0, exp_res, 0);
      end

      $display("tests %0d, failed %0d", tests, fails);
      if (fails == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== testbench/fpu_patterns.hex ====
// instr rs1 rs2 rs3 expected busy_cycles, one test per line
// sign and move first, then add/sub/mul, fused, compare and min/max
08000014 3F800000 C0000000 00000000 BF800000 0
08000414 3F800000 C0000000 00000000 3F800000 0
08000814 BF800000 C0000000 00000000 3F800000 0
38000414 3F800000 00000000 00000000 00000040 0
38000414 FF800000 00000000 00000000 00000001 0
38000414 7FC00000 00000000 00000000 00000200 0
38000414 00000001 00000000 00000000 00000020 0
38000014 12345678 00000000 00000000 12345678 0
3C000014 DEADBEEF 00000000 00000000 DEADBEEF 0
00000014 3F800000 40000000 00000000 40400000 5
00000014 3FC00000 3FC00000 00000000 40400000 5
02000014 40A00000 40000000 00000000 40400000 5
00000014 3F800000 33C00000 00000000 3F800000 5
00000014 C0400000 3F800000 00000000 C0000000 5
02000014 3F800000 30800000 00000000 3F7FFFFF 5
00000014 3F800000 00000001 00000000 3F800000 5
04000014 40000000 40400000 00000000 40C00000 1
04000014 BFC00000 40000000 00000000 C0400000 1
04000014 3FC00000 3F800001 00000000 3FC00001 1
00000010 40000000 40400000 3F800000 40E00000 5
00000011 40000000 40400000 3F800000 40A00000 5
00000012 40000000 40400000 3F800000 C0A00000 5
00000013 40000000 40400000 3F800000 C0E00000 5
00000010 3FC00000 40000000 C0800000 BF800000 5
28000814 3F800000 3F800000 00000000 00000001 2
28000814 40000000 C0000000 00000000 00000000 2
28000414 C0000000 40000000 00000000 00000001 2
28000414 BF800000 C0000000 00000000 00000000 2
28000014 40400000 40400000 00000000 00000001 2
28000014 40000000 3FC00000 00000000 00000000 2
0A000014 C0000000 40000000 00000000 C0000000 2
0A000414 C0000000 40000000 00000000 40000000 2
0A000014 BF800000 C0400000 00000000 C0400000 2
0A000414 3FC00000 3F000000 00000000 3FC00000 2
0A000014 40000000 C0000000 00000000 C0000000 2

// ==== project.f ====
+incdir+include
source/rv32f_pkg.sv
source/fpu_micro_pkg.sv
source/leading_zero_counter.sv
source/rv32f_decoder.sv
source/fpu_microsequencer.sv
source/fpu_datapath.sv
source/fp_sign_class.sv
source/rv32f_fpu.sv
testbench/tb_clock_gen.sv
testbench/tb_rv32f_fpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_rv32f_fpu -Mdir obj_dir

output="$(./obj_dir/Vtb_rv32f_fpu)"
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
   exit 0
else
   exit 1
fi
